/* compile.f */
rtl/regblk_pkg.sv
rtl/axil_write_decode.sv
rtl/reg_file.sv
rtl/action_ctrl.sv
rtl/axil_read_mux.sv
rtl/axil_reg_slave.sv
sim/tb_axil_reg_slave.sv

/* run.sh */
#!/usr/bin/env bash
# Verilator build and run of the register slave testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_axil_reg_slave -Mdir obj_dir \
   && ./obj_dir/Vtb_axil_reg_slave | tee /dev/stderr | grep -q "Test completed successfully" \
   && echo "Simulation passed" \
   || { echo "Simulation did not pass"; exit 1; }

/* sim/tb_axil_reg_slave.sv */
// Table-driven testbench for the AXI-Lite register slave with bus tasks, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_axil_reg_slave;

   localparam int num_entries = 16;
   localparam int watchdog_cycles = 40 * num_entries + 400;
   localparam logic [31:0] atype = 32'hA1B2_0007;
   localparam logic [31:0] aver  = 32'h0000_0103;

   // Writable user registers used by the random table
   localparam logic [31:0] table_offsets [8] = '{
      regblk_pkg::off_snap_context, regblk_pkg::off_user_control,
      regblk_pkg::off_src_lo, regblk_pkg::off_src_hi,
      regblk_pkg::off_tgt_lo, regblk_pkg::off_tgt_hi,
      regblk_pkg::off_mb_w, regblk_pkg::off_mb_h
   };
   // Every mapped word including the read-only ones
   localparam logic [31:0] mapped_offsets [13] = '{
      regblk_pkg::off_snap_control, regblk_pkg::off_action_type,
      regblk_pkg::off_action_version, regblk_pkg::off_snap_context,
      regblk_pkg::off_user_status, regblk_pkg::off_user_control,
      regblk_pkg::off_src_lo, regblk_pkg::off_src_hi,
      regblk_pkg::off_tgt_lo, regblk_pkg::off_tgt_hi,
      regblk_pkg::off_mb_w, regblk_pkg::off_mb_h, regblk_pkg::off_soft_reset
   };

   logic        clk;
   logic        rst_n;
   logic [31:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic        bvalid;
   logic [1:0]  bresp;
   logic        bready;
   logic [31:0] araddr;
   logic        arvalid;
   logic        arready;
   logic        rvalid;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rready;
   logic        done_pulse;
   logic        rd_error;
   logic        wr_error;
   logic        start_pulse;
   logic [63:0] source_address;
   logic [63:0] target_address;
   logic [31:0] mb_w;
   logic [31:0] mb_h;
   logic [31:0] snap_context;

   // Stimulus table and register model indexed by word offset
   logic [31:0] tab_off  [num_entries];
   logic [31:0] tab_data [num_entries];
   logic [3:0]  tab_strb [num_entries];
   logic [31:0] tab_exp  [num_entries];
   logic [31:0] model    [32];

   logic [31:0] rng_state = 32'd72;
   int          errors = 0;
   int          checks = 0;
   int          pulse_count = 0;
   int          misaligned = 0;

   axil_reg_slave #(.addr_width(32)) dut (
      .clk(clk), .rst_n(rst_n),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bvalid(bvalid), .bresp(bresp), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
      .done_pulse(done_pulse), .rd_error(rd_error), .wr_error(wr_error),
      .action_type(atype), .action_version(aver), .start_pulse(start_pulse),
      .source_address(source_address), .target_address(target_address),
      .mb_w(mb_w), .mb_h(mb_h), .snap_context(snap_context)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Start pulse count and pulses seen outside the write response cycle
   always @(posedge clk) begin
      if (start_pulse) begin
         pulse_count <= pulse_count + 1;
         if (!bvalid) begin
            misaligned <= misaligned + 1;
         end
      end
   end

   // Hang guard sized from the table length
   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout: no end of test after %0d clock cycles", watchdog_cycles);
      $display("Test failed");
      $finish;
   end

   function automatic logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // One byte of ones per set strobe
   function automatic logic [31:0] strobe_to_mask(input logic [3:0] strb);
      logic [31:0] m;
      for (int i = 0; i < 4; i++) begin
         m[8*i +: 8] = strb[i] ? 8'hFF : 8'h00;
      end
      return m;
   endfunction

   task automatic compare_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   // ------------------------------------------------------------------------
   // Bus tasks
   // ------------------------------------------------------------------------
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      do @(posedge clk); while (!awready);
      // Address taken so the data phase follows
      awvalid <= 1'b0;
      wdata   <= data;
      wstrb   <= strb;
      wvalid  <= 1'b1;
      do @(posedge clk); while (!wready);
      wvalid <= 1'b0;
      do @(posedge clk); while (!bvalid);
      compare_word("bresp", {30'd0, bresp}, {30'd0, regblk_pkg::resp_okay});
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      do @(posedge clk); while (!arready);
      arvalid <= 1'b0;
      do @(posedge clk); while (!rvalid);
      data = rdata;
      compare_word("rresp", {30'd0, rresp}, {30'd0, regblk_pkg::resp_okay});
   endtask

   // Register map and handshake outputs as they are out of reset
   task automatic check_cleared(input string when);
      logic [31:0] got;
      logic [31:0] exp;
      @(posedge clk);
      checks++;
      if (!awready || !arready || bvalid || rvalid || start_pulse) begin
         errors++;
         $display("Fail at %0t: handshake outputs not at reset values %s", $time, when);
      end
      checks++;
      if (source_address != 0 || target_address != 0 || mb_w != 0 || mb_h != 0 ||
          snap_context != 0) begin
         errors++;
         $display("Fail at %0t: action outputs not cleared %s", $time, when);
      end
      foreach (mapped_offsets[i]) begin
         exp = 32'd0;
         if (mapped_offsets[i] == regblk_pkg::off_snap_control) exp = 32'h8;
         if (mapped_offsets[i] == regblk_pkg::off_action_type) exp = atype;
         if (mapped_offsets[i] == regblk_pkg::off_action_version) exp = aver;
         bus_read(mapped_offsets[i], got);
         compare_word($sformatf("word 0x%02h %s", mapped_offsets[i], when), got, exp);
      end
      foreach (model[i]) begin
         model[i] = 32'd0;
      end
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial begin
      logic [31:0] r;
      logic [31:0] m;
      logic [31:0] got;
      logic [31:0] held;
      int          base;
      rst_n      <= 1'b0;
      awaddr     <= '0;
      awvalid    <= 1'b0;
      wdata      <= '0;
      wstrb      <= '0;
      wvalid     <= 1'b0;
      bready     <= 1'b1;
      araddr     <= '0;
      arvalid    <= 1'b0;
      rready     <= 1'b1;
      done_pulse <= 1'b0;
      rd_error   <= 1'b0;
      wr_error   <= 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      check_cleared("after reset");

      // Table built up front with expected values from the byte merge rule
      for (int i = 0; i < num_entries; i++) begin
         r           = xorshift();
         tab_off[i]  = table_offsets[r[2:0]];
         tab_strb[i] = r[7:4];
         tab_data[i] = xorshift();
         // Start and finish bits stay clear in the table
         if (tab_off[i] == regblk_pkg::off_user_control) begin
            tab_data[i][1:0] = 2'b00;
         end
         m           = strobe_to_mask(tab_strb[i]);
         model[tab_off[i][6:2]] = (tab_data[i] & m) | (model[tab_off[i][6:2]] & ~m);
         tab_exp[i]  = model[tab_off[i][6:2]];
      end
      for (int i = 0; i < num_entries; i++) begin
         bus_write(tab_off[i], tab_data[i], tab_strb[i]);
         bus_read(tab_off[i], got);
         compare_word($sformatf("table entry %0d", i), got, tab_exp[i]);
      end
      compare_word("source_address lo", source_address[31:0], model[14]);
      compare_word("source_address hi", source_address[63:32], model[15]);
      compare_word("target_address lo", target_address[31:0], model[16]);
      compare_word("target_address hi", target_address[63:32], model[17]);
      compare_word("mb_w", mb_w, model[20]);
      compare_word("mb_h", mb_h, model[21]);
      compare_word("snap_context", snap_context, model[8]);

      // Read-only words ignore writes and holes give the filler
      bus_write(regblk_pkg::off_action_type, 32'hFFFF_FFFF, 4'hF);
      bus_read(regblk_pkg::off_action_type, got);
      compare_word("action_type", got, atype);
      bus_read(regblk_pkg::off_action_version, got);
      compare_word("action_version", got, aver);
      // Writable words untouched by the read-only write
      foreach (table_offsets[i]) begin
         bus_read(table_offsets[i], got);
         compare_word($sformatf("word 0x%02h after read-only write", table_offsets[i]),
                      got, model[table_offsets[i][6:2]]);
      end
      bus_read(32'h60, got);
      compare_word("unmapped 0x60", got, 32'h5A5AA5A5);

      // Start pulse on a 0 to 1 change only
      bus_write(regblk_pkg::off_user_control, 32'h0, 4'hF);
      repeat (3) @(posedge clk);
      base = pulse_count;
      bus_write(regblk_pkg::off_user_control, 32'h1, 4'hF);
      repeat (3) @(posedge clk);
      compare_word("start pulses after set", pulse_count - base, 32'd1);
      bus_write(regblk_pkg::off_user_control, 32'h1, 4'hF);
      repeat (3) @(posedge clk);
      compare_word("start pulses after rewrite", pulse_count - base, 32'd1);
      compare_word("start pulses outside bvalid", misaligned, 32'd0);

      // Idle flag from finish
      bus_read(regblk_pkg::off_snap_control, got);
      compare_word("snap control before finish", got, 32'h8);
      bus_write(regblk_pkg::off_user_control, 32'h2, 4'hF);
      bus_read(regblk_pkg::off_snap_control, got);
      compare_word("snap control after finish", got, 32'hC);

      // Stored upper bits with ready, idle and delayed start in the low nibble
      bus_write(regblk_pkg::off_snap_control, 32'hABCD_1233, 4'hF);
      bus_read(regblk_pkg::off_snap_control, got);
      compare_word("snap control readback", got, 32'hABCD_123D);

      // Sticky status flags set by one pulse at a time
      @(posedge clk);
      done_pulse <= 1'b1;
      @(posedge clk);
      done_pulse <= 1'b0;
      bus_read(regblk_pkg::off_user_status, got);
      compare_word("user status after done", got, 32'h1);
      @(posedge clk);
      wr_error <= 1'b1;
      @(posedge clk);
      wr_error <= 1'b0;
      bus_read(regblk_pkg::off_user_status, got);
      compare_word("user status after write error", got, 32'h3);
      @(posedge clk);
      rd_error <= 1'b1;
      @(posedge clk);
      rd_error <= 1'b0;
      bus_read(regblk_pkg::off_user_status, got);
      compare_word("user status after read error", got, 32'h7);
      repeat (4) @(posedge clk);
      bus_read(regblk_pkg::off_user_status, got);
      compare_word("user status held", got, 32'h7);

      // Read held under back-pressure
      @(posedge clk);
      rready  <= 1'b0;
      araddr  <= regblk_pkg::off_mb_h;
      arvalid <= 1'b1;
      do @(posedge clk); while (!arready);
      arvalid <= 1'b0;
      do @(posedge clk); while (!rvalid);
      held = rdata;
      compare_word("held read", held, model[21]);
      repeat (3) begin
         @(posedge clk);
         checks++;
         if (!rvalid || rdata !== held) begin
            errors++;
            $display("Fail at %0t: read changed while rready was low", $time);
         end
      end
      rready <= 1'b1;
      repeat (2) @(posedge clk);
      compare_word("rvalid after release", {31'd0, rvalid}, 32'd0);

      bus_write(regblk_pkg::off_soft_reset, 32'h1, 4'h1);
      check_cleared("after soft reset");

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/axil_reg_slave.sv */
// AXI-Lite register slave top level joining decode, register file, action control and read mux
`timescale 1ns/1ps
`default_nettype none

module axil_reg_slave #(
   parameter int addr_width = 32
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   // AXI-Lite write side
   input  logic [addr_width-1:0]                  awaddr,
   input  logic                                   awvalid,
   output logic                                   awready,
   input  logic [regblk_pkg::data_width-1:0]      wdata,
   input  logic [regblk_pkg::strb_width-1:0]      wstrb,
   input  logic                                   wvalid,
   output logic                                   wready,
   output logic                                   bvalid,
   output logic [1:0]                             bresp,
   input  logic                                   bready,
   // AXI-Lite read side
   input  logic [addr_width-1:0]                  araddr,
   input  logic                                   arvalid,
   output logic                                   arready,
   output logic                                   rvalid,
   output logic [regblk_pkg::data_width-1:0]      rdata,
   output logic [1:0]                             rresp,
   input  logic                                   rready,
   // Action side
   input  logic                                   done_pulse,
   input  logic                                   rd_error,
   input  logic                                   wr_error,
   input  logic [regblk_pkg::data_width-1:0]      action_type,
   input  logic [regblk_pkg::data_width-1:0]      action_version,
   output logic                                   start_pulse,
   output logic [2*regblk_pkg::data_width-1:0]    source_address,
   output logic [2*regblk_pkg::data_width-1:0]    target_address,
   output logic [regblk_pkg::data_width-1:0]      mb_w,
   output logic [regblk_pkg::data_width-1:0]      mb_h,
   output logic [regblk_pkg::data_width-1:0]      snap_context
);

   localparam int dw = regblk_pkg::data_width;

   // Decode to register file
   logic                 wr_en;
   regblk_pkg::reg_sel_e wr_sel;
   logic [dw-1:0]        wr_data;
   logic [dw-1:0]        wr_mask;
   // Register file to control and read mux
   logic [dw-1:0]        snap_control;
   logic [dw-1:0]        user_control;
   logic [dw-1:0]        soft_reset_word;
   logic                 soft_reset;
   logic                 start_bit;
   logic                 finish_bit;
   logic                 snap_start_bit;
   // Control to read mux
   logic                 snap_start_q;
   logic                 snap_idle;
   logic [dw-1:0]        user_status;

   // ------------------------------------------------------------------------
   // Write path
   // ------------------------------------------------------------------------
   axil_write_decode #(.addr_width(addr_width)) u_write_decode (
      .clk(clk), .rst_n(rst_n),
      .awaddr(awaddr), .awvalid(awvalid), .wdata(wdata), .wstrb(wstrb),
      .wvalid(wvalid), .bready(bready),
      .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
      .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data), .wr_mask(wr_mask)
   );

   reg_file u_reg_file (
      .clk(clk), .rst_n(rst_n),
      .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data), .wr_mask(wr_mask),
      .snap_control(snap_control), .snap_context(snap_context),
      .user_control(user_control), .source_address(source_address),
      .target_address(target_address), .mb_w(mb_w), .mb_h(mb_h),
      .soft_reset_word(soft_reset_word), .soft_reset(soft_reset),
      .start_bit(start_bit), .finish_bit(finish_bit), .snap_start_bit(snap_start_bit)
   );

   // ------------------------------------------------------------------------
   // Action control and read path
   // ------------------------------------------------------------------------
   action_ctrl u_action_ctrl (
      .clk(clk), .rst_n(rst_n), .soft_reset(soft_reset),
      .start_bit(start_bit), .finish_bit(finish_bit), .snap_start_bit(snap_start_bit),
      .done_pulse(done_pulse), .rd_error(rd_error), .wr_error(wr_error),
      .start_pulse(start_pulse), .snap_start_q(snap_start_q), .snap_idle(snap_idle),
      .user_status(user_status)
   );

   axil_read_mux #(.addr_width(addr_width)) u_read_mux (
      .clk(clk), .rst_n(rst_n),
      .araddr(araddr), .arvalid(arvalid), .rready(rready),
      .snap_control(snap_control), .snap_start_q(snap_start_q), .snap_idle(snap_idle),
      .action_type(action_type), .action_version(action_version),
      .snap_context(snap_context), .user_status(user_status),
      .user_control(user_control), .source_address(source_address),
      .target_address(target_address), .mb_w(mb_w), .mb_h(mb_h),
      .soft_reset_word(soft_reset_word),
      .arready(arready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp)
   );

endmodule

`default_nettype wire

/* rtl/axil_read_mux.sv */
// AXI-Lite read handshake and registered read data multiplexer
`timescale 1ns/1ps
`default_nettype none

module axil_read_mux #(
   parameter int addr_width = 32
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic [addr_width-1:0]                  araddr,
   input  logic                                   arvalid,
   input  logic                                   rready,
   input  logic [regblk_pkg::data_width-1:0]      snap_control,
   input  logic                                   snap_start_q,
   input  logic                                   snap_idle,
   input  logic [regblk_pkg::data_width-1:0]      action_type,
   input  logic [regblk_pkg::data_width-1:0]      action_version,
   input  logic [regblk_pkg::data_width-1:0]      snap_context,
   input  logic [regblk_pkg::data_width-1:0]      user_status,
   input  logic [regblk_pkg::data_width-1:0]      user_control,
   input  logic [2*regblk_pkg::data_width-1:0]    source_address,
   input  logic [2*regblk_pkg::data_width-1:0]    target_address,
   input  logic [regblk_pkg::data_width-1:0]      mb_w,
   input  logic [regblk_pkg::data_width-1:0]      mb_h,
   input  logic [regblk_pkg::data_width-1:0]      soft_reset_word,
   output logic                                   arready,
   output logic                                   rvalid,
   output logic [regblk_pkg::data_width-1:0]      rdata,
   output logic [1:0]                             rresp
);

   localparam int dw = regblk_pkg::data_width;

   logic [dw-1:0] ar_word;
   logic [dw-1:0] snap_control_rd;
   logic          ar_hs;

   assign ar_hs   = arvalid & arready;
   assign ar_word = dw'(araddr);

   // Bit 3 ready is tied high, bit 1 done is unused
   assign snap_control_rd = {snap_control[dw-1:4], 1'b1, snap_idle, 1'b0, snap_start_q};

   // ------------------------------------------------------------------------
   // Read handshake
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b1;
         rvalid  <= 1'b0;
      end else begin
         if (arvalid) begin
            arready <= 1'b0;
         end else if (rvalid && rready) begin
            arready <= 1'b1;
         end
         // Held through back-pressure
         if (ar_hs) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // Result stage, one cycle of latency
   always_ff @(posedge clk) begin
      if (ar_hs) begin
         case (ar_word)
            regblk_pkg::off_snap_control   : rdata <= snap_control_rd;
            regblk_pkg::off_action_type    : rdata <= action_type;
            regblk_pkg::off_action_version : rdata <= action_version;
            regblk_pkg::off_snap_context   : rdata <= snap_context;
            regblk_pkg::off_user_status    : rdata <= user_status;
            regblk_pkg::off_user_control   : rdata <= user_control;
            regblk_pkg::off_src_lo         : rdata <= source_address[dw-1:0];
            regblk_pkg::off_src_hi         : rdata <= source_address[2*dw-1:dw];
            regblk_pkg::off_tgt_lo         : rdata <= target_address[dw-1:0];
            regblk_pkg::off_tgt_hi         : rdata <= target_address[2*dw-1:dw];
            regblk_pkg::off_mb_w           : rdata <= mb_w;
            regblk_pkg::off_mb_h           : rdata <= mb_h;
            regblk_pkg::off_soft_reset     : rdata <= soft_reset_word;
            default                        : rdata <= regblk_pkg::unmapped_word;
         endcase
      end
   end

   assign rresp = regblk_pkg::resp_okay;

endmodule

`default_nettype wire

/* rtl/action_ctrl.sv */
// Start edge detect, delayed snap start, idle flag and sticky status flags
`timescale 1ns/1ps
`default_nettype none

module action_ctrl (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   soft_reset,
   input  logic                                   start_bit,
   input  logic                                   finish_bit,
   input  logic                                   snap_start_bit,
   input  logic                                   done_pulse,
   input  logic                                   rd_error,
   input  logic                                   wr_error,
   output logic                                   start_pulse,
   output logic                                   snap_start_q,
   output logic                                   snap_idle,
   output logic [regblk_pkg::data_width-1:0]      user_status
);

   logic start_q;
   logic done_q;
   logic wr_err_q;
   logic rd_err_q;

   // ------------------------------------------------------------------------
   // Control flow state
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         start_q      <= 1'b0;
         snap_start_q <= 1'b0;
         snap_idle    <= 1'b0;
         done_q       <= 1'b0;
         wr_err_q     <= 1'b0;
         rd_err_q     <= 1'b0;
      end else if (soft_reset) begin
         start_q      <= 1'b0;
         snap_start_q <= 1'b0;
         snap_idle    <= 1'b0;
         done_q       <= 1'b0;
         wr_err_q     <= 1'b0;
         rd_err_q     <= 1'b0;
      end else begin
         // Previous-cycle copies for edge detect
         start_q      <= start_bit;
         snap_start_q <= snap_start_bit;
         // Finish from software marks the action idle
         if (finish_bit) begin
            snap_idle <= 1'b1;
         end
         // Sticky until the next reset
         if (done_pulse) begin
            done_q <= 1'b1;
         end
         if (wr_error) begin
            wr_err_q <= 1'b1;
         end
         if (rd_error) begin
            rd_err_q <= 1'b1;
         end
      end
   end

   // Rising edge of control bit 0 only
   assign start_pulse = start_bit & ~start_q;

   // Status word layout: rd_err, wr_err, done from bit 2 down
   assign user_status = {{(regblk_pkg::data_width-3){1'b0}}, rd_err_q, wr_err_q, done_q};

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
// User register storage with byte-masked and half-word updates and soft reset
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   wr_en,
   input  regblk_pkg::reg_sel_e                   wr_sel,
   input  logic [regblk_pkg::data_width-1:0]      wr_data,
   input  logic [regblk_pkg::data_width-1:0]      wr_mask,
   output logic [regblk_pkg::data_width-1:0]      snap_control,
   output logic [regblk_pkg::data_width-1:0]      snap_context,
   output logic [regblk_pkg::data_width-1:0]      user_control,
   output logic [2*regblk_pkg::data_width-1:0]    source_address,
   output logic [2*regblk_pkg::data_width-1:0]    target_address,
   output logic [regblk_pkg::data_width-1:0]      mb_w,
   output logic [regblk_pkg::data_width-1:0]      mb_h,
   output logic [regblk_pkg::data_width-1:0]      soft_reset_word,
   output logic                                   soft_reset,
   output logic                                   start_bit,
   output logic                                   finish_bit,
   output logic                                   snap_start_bit
);

   localparam int dw = regblk_pkg::data_width;

   // New bytes where the mask is set, old bytes elsewhere
   function automatic logic [dw-1:0] merge(input logic [dw-1:0] old_val);
      return (wr_data & wr_mask) | (old_val & ~wr_mask);
   endfunction

   // ------------------------------------------------------------------------
   // Execute stage
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snap_control    <= '0;
         snap_context    <= '0;
         user_control    <= '0;
         source_address  <= '0;
         target_address  <= '0;
         mb_w            <= '0;
         mb_h            <= '0;
         soft_reset_word <= '0;
      end else if (soft_reset) begin
         // Self-clearing, soft reset word included
         snap_control    <= '0;
         snap_context    <= '0;
         user_control    <= '0;
         source_address  <= '0;
         target_address  <= '0;
         mb_w            <= '0;
         mb_h            <= '0;
         soft_reset_word <= '0;
      end else if (wr_en) begin
         case (wr_sel)
            regblk_pkg::sel_snap_control : snap_control <= merge(snap_control);
            regblk_pkg::sel_snap_context : snap_context <= merge(snap_context);
            regblk_pkg::sel_user_control : user_control <= merge(user_control);
            // 64-bit addresses, one half per write
            regblk_pkg::sel_src_lo : source_address[dw-1:0] <= merge(source_address[dw-1:0]);
            regblk_pkg::sel_src_hi : source_address[2*dw-1:dw] <= merge(source_address[2*dw-1:dw]);
            regblk_pkg::sel_tgt_lo : target_address[dw-1:0] <= merge(target_address[dw-1:0]);
            regblk_pkg::sel_tgt_hi : target_address[2*dw-1:dw] <= merge(target_address[2*dw-1:dw]);
            regblk_pkg::sel_mb_w         : mb_w <= merge(mb_w);
            regblk_pkg::sel_mb_h         : mb_h <= merge(mb_h);
            regblk_pkg::sel_soft_reset   : soft_reset_word <= merge(soft_reset_word);
            default                      : ;
         endcase
      end
   end

   // Control bits seen by the action logic
   assign soft_reset     = soft_reset_word[0];
   assign start_bit      = user_control[0];
   assign finish_bit     = user_control[1];
   assign snap_start_bit = snap_control[0];

endmodule

`default_nettype wire

/* rtl/axil_write_decode.sv */
// AXI-Lite write address capture, aw/w/b handshake, strobe mask and register select decode
`timescale 1ns/1ps
`default_nettype none

module axil_write_decode #(
   parameter int addr_width = 32
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic [addr_width-1:0]                  awaddr,
   input  logic                                   awvalid,
   input  logic [regblk_pkg::data_width-1:0]      wdata,
   input  logic [regblk_pkg::strb_width-1:0]      wstrb,
   input  logic                                   wvalid,
   input  logic                                   bready,
   output logic                                   awready,
   output logic                                   wready,
   output logic                                   bvalid,
   output logic [1:0]                             bresp,
   output logic                                   wr_en,
   output regblk_pkg::reg_sel_e                   wr_sel,
   output logic [regblk_pkg::data_width-1:0]      wr_data,
   output logic [regblk_pkg::data_width-1:0]      wr_mask
);

   localparam int dw = regblk_pkg::data_width;

   logic [addr_width-1:0] aw_addr_q;
   logic [dw-1:0]         aw_word;
   logic                  aw_hs;

   assign aw_hs = awvalid & awready;
   assign wr_en = wvalid & wready;

   // Held address, loaded on the aw handshake only
   always_ff @(posedge clk) begin
      if (aw_hs) begin
         aw_addr_q <= awaddr;
      end
   end

   // ------------------------------------------------------------------------
   // Handshake flags
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         awready <= 1'b1;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         // Any awvalid drops awready, even mid-burst
         if (awvalid) begin
            awready <= 1'b0;
         end else if (wr_en) begin
            awready <= 1'b1;
         end
         // Data phase opens one edge after the address
         if (aw_hs) begin
            wready <= 1'b1;
         end else if (wvalid) begin
            wready <= 1'b0;
         end
         // Response held until the master is ready
         if (wr_en) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   assign bresp = regblk_pkg::resp_okay;

   // ------------------------------------------------------------------------
   // Decode stage
   // ------------------------------------------------------------------------
   assign aw_word = dw'(aw_addr_q);

   // Read-only and unknown offsets fall to sel_none
   always_comb begin
      case (aw_word)
         regblk_pkg::off_snap_control : wr_sel = regblk_pkg::sel_snap_control;
         regblk_pkg::off_snap_context : wr_sel = regblk_pkg::sel_snap_context;
         regblk_pkg::off_user_control : wr_sel = regblk_pkg::sel_user_control;
         regblk_pkg::off_src_lo       : wr_sel = regblk_pkg::sel_src_lo;
         regblk_pkg::off_src_hi       : wr_sel = regblk_pkg::sel_src_hi;
         regblk_pkg::off_tgt_lo       : wr_sel = regblk_pkg::sel_tgt_lo;
         regblk_pkg::off_tgt_hi       : wr_sel = regblk_pkg::sel_tgt_hi;
         regblk_pkg::off_mb_w         : wr_sel = regblk_pkg::sel_mb_w;
         regblk_pkg::off_mb_h         : wr_sel = regblk_pkg::sel_mb_h;
         regblk_pkg::off_soft_reset   : wr_sel = regblk_pkg::sel_soft_reset;
         default                      : wr_sel = regblk_pkg::sel_none;
      endcase
   end

   // Byte strobes widened to a bit mask
   always_comb begin
      for (int i = 0; i < regblk_pkg::strb_width; i++) begin
         wr_mask[8*i +: 8] = {8{wstrb[i]}};
      end
   end

   assign wr_data = wdata;

endmodule

`default_nettype wire

/* rtl/regblk_pkg.sv */
// Bus widths, register offsets, write selector enum, filler word and response code
`default_nettype none

package regblk_pkg;

   // ------------------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------------------
   // Fixed at one 32-bit word, four byte lanes
   parameter int data_width = 32;
   parameter int strb_width = data_width / 8;

   // ------------------------------------------------------------------------
   // Register map
   // ------------------------------------------------------------------------
   // Framework registers
   parameter logic [data_width-1:0] off_snap_control   = 32'h00;
   parameter logic [data_width-1:0] off_action_type    = 32'h10;
   parameter logic [data_width-1:0] off_action_version = 32'h14;
   parameter logic [data_width-1:0] off_snap_context   = 32'h20;
   // User registers
   parameter logic [data_width-1:0] off_user_status    = 32'h30;
   parameter logic [data_width-1:0] off_user_control   = 32'h34;
   parameter logic [data_width-1:0] off_src_lo         = 32'h38;
   parameter logic [data_width-1:0] off_src_hi         = 32'h3C;
   parameter logic [data_width-1:0] off_tgt_lo         = 32'h40;
   parameter logic [data_width-1:0] off_tgt_hi         = 32'h44;
   parameter logic [data_width-1:0] off_mb_w           = 32'h50;
   parameter logic [data_width-1:0] off_mb_h           = 32'h54;
   parameter logic [data_width-1:0] off_soft_reset     = 32'h58;

   // Writable register selector, one code per storage target
   typedef enum logic [3:0] {
      sel_none,
      sel_snap_control,
      sel_snap_context,
      sel_user_control,
      sel_src_lo,
      sel_src_hi,
      sel_tgt_lo,
      sel_tgt_hi,
      sel_mb_w,
      sel_mb_h,
      sel_soft_reset
   } reg_sel_e;

   // Read value for holes in the map
   parameter logic [data_width-1:0] unmapped_word = 32'h5A5AA5A5;

   // Only response ever returned
   parameter logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire
